// File: filelist.f
+incdir+verilog
verilog/lsuPkg.sv
verilog/lsuAlignCheck.sv
verilog/lsuReservation.sv
verilog/lsuDataRam.sv
verilog/lsuSubwordRead.sv
verilog/lsu.sv
tb/lsuTb.sv

// File: tb/lsuTb.sv
// Load/store unit testbench
`timescale 1ns/10ps
`default_nettype none
`include "lsu_defines.svh"

module lsuTb;

  // One table row, request plus what the response must show
  typedef struct packed {
    lsuPkg::lsuReqT       req;
    logic                 flush;
    logic                 expValid;
    logic [`LSU_XLEN-1:0] expData;
    logic                 expLoadFault;
    logic                 expStoreFault;
    logic                 expSquash;
  } entryT;

  localparam lsuPkg::memRwT opIdle = lsuPkg::memIdle;
  localparam lsuPkg::memRwT opRd = lsuPkg::memRead;
  localparam lsuPkg::memRwT opWr = lsuPkg::memWrite;
  localparam lsuPkg::atomicT atNone = lsuPkg::atomicNone;
  localparam lsuPkg::atomicT atLr = lsuPkg::atomicLr;
  localparam lsuPkg::atomicT atSc = lsuPkg::atomicSc;

  // funct3 codes, bit 2 is unsigned
  localparam logic [2:0] szB = 3'b000;
  localparam logic [2:0] szH = 3'b001;
  localparam logic [2:0] szW = 3'b010;
  localparam logic [2:0] szD = 3'b011;
  localparam logic [2:0] szBu = 3'b100;
  localparam logic [2:0] szHu = 3'b101;

  logic            clk;
  logic            rstN;
  logic            flush;
  lsuPkg::lsuReqT  req;
  lsuPkg::lsuRespT resp;

  entryT           stimTable[$];
  lsuPkg::lsuRespT expQueue[$];
  // Cycle in which each expected response was issued
  int              pushTime[$];
  logic [31:0]     lcgState = 32'd7341;
  logic [31:0]     refMem [`LSU_MEM_WORDS];
  int              errors = 0;
  int              unexpected = 0;
  int              missing = 0;
  int              cycleCount = 0;
  int              cycleLimit = 0;

  lsu dut0 (
    .clk   (clk),
    .rstN  (rstN),
    .flush (flush),
    .req   (req),
    .resp  (resp)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // LCG step for store data
  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
    if (actVal !== expVal) begin
      errors++;
      $display("FAILED %s expected %h got %h", name, expVal, actVal);
    end
  endtask

  task automatic addOp(input lsuPkg::memRwT rw, input lsuPkg::atomicT at,
                       input logic [2:0] f3, input logic [31:0] adr,
                       input logic [31:0] data, input logic fl);
    entryT e;
    e = '0;
    e.req.memRw = rw;
    e.req.atomic = at;
    e.req.funct3 = f3;
    e.req.adr = adr;
    e.req.writeData = data;
    e.flush = fl;
    stimTable.push_back(e);
  endtask

  //////////////////////////////
  // Stimulus table
  //////////////////////////////
  task automatic buildTable();
    // Word stores, one load right behind its store
    addOp(opWr, atNone, szW, 32'h00, nextRandom(), 1'b0);
    addOp(opWr, atNone, szW, 32'h04, nextRandom(), 1'b0);
    addOp(opRd, atNone, szW, 32'h04, 32'h0, 1'b0);
    addOp(opRd, atNone, szW, 32'h00, 32'h0, 1'b0);
    // Byte and half writes into a random word
    addOp(opWr, atNone, szW, 32'h10, nextRandom(), 1'b0);
    addOp(opWr, atNone, szB, 32'h11, nextRandom(), 1'b0);
    addOp(opWr, atNone, szH, 32'h12, nextRandom(), 1'b0);
    addOp(opRd, atNone, szW, 32'h10, 32'h0, 1'b0);
    // Fixed words with both sign polarities per lane
    addOp(opWr, atNone, szW, 32'h14, 32'h8F7E_F001, 1'b0);
    addOp(opWr, atNone, szW, 32'h18, 32'h7FFF_8000, 1'b0);
    for (int ofs = 0; ofs < 4; ofs++) begin
      addOp(opRd, atNone, szB, 32'h14 + ofs, 32'h0, 1'b0);
      addOp(opRd, atNone, szBu, 32'h14 + ofs, 32'h0, 1'b0);
      addOp(opRd, atNone, szB, 32'h10 + ofs, 32'h0, 1'b0);
    end
    for (int ofs = 0; ofs < 4; ofs += 2) begin
      addOp(opRd, atNone, szH, 32'h14 + ofs, 32'h0, 1'b0);
      addOp(opRd, atNone, szHu, 32'h18 + ofs, 32'h0, 1'b0);
      addOp(opRd, atNone, szH, 32'h18 + ofs, 32'h0, 1'b0);
    end
    // Misaligned loads and stores, then word 0 must be intact
    addOp(opRd, atNone, szH, 32'h11, 32'h0, 1'b0);
    addOp(opRd, atNone, szW, 32'h12, 32'h0, 1'b0);
    addOp(opRd, atNone, szD, 32'h00, 32'h0, 1'b0);
    addOp(opRd, atNone, szHu, 32'h13, 32'h0, 1'b0);
    addOp(opWr, atNone, szH, 32'h03, nextRandom(), 1'b0);
    addOp(opWr, atNone, szW, 32'h02, nextRandom(), 1'b0);
    addOp(opRd, atNone, szW, 32'h00, 32'h0, 1'b0);
    // LR/SC pass, second SC fails
    addOp(opWr, atNone, szW, 32'h20, nextRandom(), 1'b0);
    addOp(opWr, atNone, szW, 32'h24, nextRandom(), 1'b0);
    addOp(opRd, atLr, szW, 32'h20, 32'h0, 1'b0);
    addOp(opWr, atSc, szW, 32'h20, nextRandom(), 1'b0);
    addOp(opRd, atNone, szW, 32'h20, 32'h0, 1'b0);
    addOp(opWr, atSc, szW, 32'h20, nextRandom(), 1'b0);
    addOp(opRd, atNone, szW, 32'h20, 32'h0, 1'b0);
    // SC to another word than the reserved one
    addOp(opRd, atLr, szW, 32'h20, 32'h0, 1'b0);
    addOp(opWr, atSc, szW, 32'h24, nextRandom(), 1'b0);
    addOp(opRd, atNone, szW, 32'h24, 32'h0, 1'b0);
    // Plain store between LR and SC keeps the reservation
    addOp(opRd, atLr, szW, 32'h24, 32'h0, 1'b0);
    addOp(opWr, atNone, szW, 32'h28, nextRandom(), 1'b0);
    addOp(opWr, atSc, szW, 32'h24, nextRandom(), 1'b0);
    addOp(opRd, atNone, szW, 32'h24, 32'h0, 1'b0);
    // Flushed requests and an idle slot give no response
    addOp(opWr, atNone, szW, 32'h04, nextRandom(), 1'b1);
    addOp(opRd, atNone, szW, 32'h04, 32'h0, 1'b1);
    addOp(opIdle, atNone, szW, 32'h04, 32'h0, 1'b0);
    addOp(opRd, atNone, szW, 32'h04, 32'h0, 1'b0);
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////
  // Walks the table in order, one op at a time
  task automatic fillExpected();
    entryT                         e;
    logic [1:0]                    size;
    logic [1:0]                    ofs;
    logic [`LSU_WORD_ADR_BITS-1:0] wAdr;
    logic [`LSU_WORD_ADR_BITS-1:0] resAdr;
    logic                          resValid;
    logic                          bad;
    logic [31:0]                   word;
    logic [7:0]                    b;
    logic [15:0]                   h;
    resValid = 1'b0;
    resAdr = '0;
    for (int i = 0; i < stimTable.size(); i++) begin
      e = stimTable[i];
      size = e.req.funct3[1:0];
      ofs = e.req.adr[1:0];
      wAdr = e.req.adr[`LSU_WORD_ADR_BITS+1:2];
      bad = (size == 2'b11) || (size == 2'b01 && ofs[0]) || (size == 2'b10 && ofs != 2'b00);
      e.expValid = ((e.req.memRw != opIdle) || (e.req.atomic != atNone)) && !e.flush;
      if (e.expValid) begin
        if (e.req.atomic == atSc) begin
          // SC without a matching reservation fails and writes nothing
          if (bad) begin
            e.expStoreFault = 1'b1;
            e.expSquash = 1'b1;
          end else if (resValid && resAdr == wAdr) begin
            refMem[wAdr] = e.req.writeData;
          end else begin
            e.expData = 32'd1;
            e.expSquash = 1'b1;
          end
          resValid = 1'b0;
        end else if (e.req.memRw == opRd) begin
          if (bad) begin
            e.expLoadFault = 1'b1;
          end else begin
            word = refMem[wAdr];
            b = word[8*ofs +: 8];
            h = word[8*ofs +: 16];
            case (size)
              2'b00: e.expData = e.req.funct3[2] ? {24'h0, b} : {{24{b[7]}}, b};
              2'b01: e.expData = e.req.funct3[2] ? {16'h0, h} : {{16{h[15]}}, h};
              default: e.expData = word;
            endcase
            if (e.req.atomic == atLr) begin
              resValid = 1'b1;
              resAdr = wAdr;
            end
          end
        end else if (bad) begin
          e.expStoreFault = 1'b1;
        end else begin
          case (size)
            2'b00: refMem[wAdr][8*ofs +: 8] = e.req.writeData[7:0];
            2'b01: refMem[wAdr][8*ofs +: 16] = e.req.writeData[15:0];
            default: refMem[wAdr] = e.req.writeData;
          endcase
        end
      end
      stimTable[i] = e;
    end
  endtask

  //////////////////////////////
  // Response check
  //////////////////////////////
  // Each response must land three cycles after its request
  task automatic checkResponse();
    lsuPkg::lsuRespT exp;
    int              sent;
    if (resp.valid === 1'b1) begin
      if (expQueue.size() == 0) begin
        unexpected++;
        $display("Response arrived with no request pending, readData %h", resp.readData);
      end else begin
        exp = expQueue.pop_front();
        sent = pushTime.pop_front();
        checkValue("resp latency", 32'd3, cycleCount - sent);
        checkValue("resp.readData", exp.readData, resp.readData);
        checkValue("resp.loadMisalignedFault", exp.loadMisalignedFault,
                   resp.loadMisalignedFault);
        checkValue("resp.storeMisalignedFault", exp.storeMisalignedFault,
                   resp.storeMisalignedFault);
        checkValue("resp.squashSc", exp.squashSc, resp.squashSc);
      end
    end
  endtask

  task automatic pushExpected(input entryT e);
    lsuPkg::lsuRespT r;
    r.valid = 1'b1;
    r.readData = e.expData;
    r.loadMisalignedFault = e.expLoadFault;
    r.storeMisalignedFault = e.expStoreFault;
    r.squashSc = e.expSquash;
    expQueue.push_back(r);
    pushTime.push_back(cycleCount);
  endtask

  // Run limit counted from reset release
  always @(posedge clk) begin
    if (rstN) begin
      cycleCount = cycleCount + 1;
      if (cycleCount > cycleLimit) begin
        $display("Timeout, run still busy after %0d cycles", cycleCount);
        $display("Checks failed");
        $finish;
      end
    end
  end

  //////////////////////////////
  // Main flow
  //////////////////////////////
  initial begin
    int drain;
    rstN = 1'b0;
    flush = 1'b0;
    req = '0;
    buildTable();
    fillExpected();
    cycleLimit = stimTable.size() + 20;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    // One table row per cycle, back to back
    for (int i = 0; i < stimTable.size(); i++) begin
      @(negedge clk);
      checkResponse();
      req = stimTable[i].req;
      flush = stimTable[i].flush;
      if (stimTable[i].expValid) begin
        pushExpected(stimTable[i]);
      end
    end
    @(negedge clk);
    checkResponse();
    req = '0;
    flush = 1'b0;
    drain = 0;
    while (expQueue.size() != 0 && drain < 6) begin
      @(negedge clk);
      checkResponse();
      drain++;
    end
    // A few idle cycles catch stray responses
    repeat (3) begin
      @(negedge clk);
      checkResponse();
    end
    missing = expQueue.size();
    if (missing != 0) begin
      $display("%0d expected responses never arrived", missing);
    end
    $display("Errors: %0d mismatches, %0d unexpected responses, %0d missing responses",
             errors, unexpected, missing);
    if (errors == 0 && unexpected == 0 && missing == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/lsu.sv
// Load/store unit top
`timescale 1ns/10ps
`default_nettype none

module lsu (
  input  logic            clk,
  input  logic            rstN,
  input  logic            flush,
  input  lsuPkg::lsuReqT  req,
  output lsuPkg::lsuRespT resp
);

  // Pipeline bundles
  lsuPkg::lsuStage1T stage1;
  lsuPkg::lsuStage2T stage2;

  // Memory control from the reservation unit
  logic ramWrite;
  logic ramRead;
  logic scFail;

  //////////////////////////////
  // Stage one
  //////////////////////////////
  lsuAlignCheck alignCheck0 (
    .clk    (clk),
    .rstN   (rstN),
    .flush  (flush),
    .req    (req),
    .stage1 (stage1)
  );

  // LR/SC and fault gating, combinational on stage one
  lsuReservation reservation0 (
    .clk      (clk),
    .rstN     (rstN),
    .stage1   (stage1),
    .ramWrite (ramWrite),
    .ramRead  (ramRead),
    .scFail   (scFail)
  );

  //////////////////////////////
  // Stage two
  //////////////////////////////
  lsuDataRam dataRam0 (
    .clk      (clk),
    .rstN     (rstN),
    .stage1   (stage1),
    .ramWrite (ramWrite),
    .ramRead  (ramRead),
    .scFail   (scFail),
    .stage2   (stage2)
  );

  //////////////////////////////
  // Stage three
  //////////////////////////////
  lsuSubwordRead subwordRead0 (
    .clk    (clk),
    .rstN   (rstN),
    .stage2 (stage2),
    .resp   (resp)
  );

endmodule

`default_nettype wire

// File: verilog/lsuAlignCheck.sv
// Request register and alignment check
`timescale 1ns/10ps
`default_nettype none
`include "lsu_defines.svh"

module lsuAlignCheck (
  input  logic              clk,
  input  logic              rstN,
  input  logic              flush,
  input  lsuPkg::lsuReqT    req,
  output lsuPkg::lsuStage1T stage1
);

  logic                 reqPresent;
  logic [1:0]           size;
  logic [1:0]           ofs;
  logic                 misaligned;
  logic [3:0]           byteEn;
  logic [`LSU_XLEN-1:0] laneData;

  // Any nonzero read/write or atomic field is a request
  assign reqPresent = (|req.memRw) | (|req.atomic);
  assign size = req.funct3[1:0];
  assign ofs = req.adr[1:0];

  //////////////////////////////
  // Misalignment by size
  //////////////////////////////
  always_comb begin
    case (size)
      2'b00:   misaligned = 1'b0;
      2'b01:   misaligned = ofs[0];
      2'b10:   misaligned = |ofs;
      // Doubleword does not exist here
      default: misaligned = 1'b1;
    endcase
  end

  //////////////////////////////
  // Byte enables and lane data
  //////////////////////////////
  // Data is replicated across lanes, the enables pick the live bytes
  always_comb begin
    case (size)
      2'b00: begin
        byteEn = 4'b0001 << ofs;
        laneData = {4{req.writeData[7:0]}};
      end
      2'b01: begin
        byteEn = 4'b0011 << ofs;
        laneData = {2{req.writeData[15:0]}};
      end
      2'b10: begin
        byteEn = 4'b1111;
        laneData = req.writeData;
      end
      default: begin
        byteEn = 4'b0000;
        laneData = req.writeData;
      end
    endcase
  end

  // Stage one register, flush squashes the request here
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      stage1 <= '0;
    end else begin
      stage1.valid <= reqPresent & ~flush;
      stage1.isLoad <= (req.memRw == lsuPkg::memRead) & (req.atomic == lsuPkg::atomicNone);
      stage1.isStore <= (req.memRw == lsuPkg::memWrite) & (req.atomic == lsuPkg::atomicNone);
      stage1.isLr <= (req.atomic == lsuPkg::atomicLr);
      stage1.isSc <= (req.atomic == lsuPkg::atomicSc);
      stage1.misaligned <= misaligned;
      stage1.funct3 <= req.funct3;
      stage1.byteOfs <= ofs;
      stage1.wordAdr <= req.adr[`LSU_WORD_ADR_BITS+1:2];
      stage1.byteEn <= byteEn;
      stage1.laneData <= laneData;
    end
  end

  // Read and write are exclusive in one request
  assert property (@(posedge clk) disable iff (!rstN) req.memRw != 2'b11)
    else $error("lsuAlignCheck: read and write both set in one request");

endmodule

`default_nettype wire

// File: verilog/lsuDataRam.sv
// Local word memory and stage two register
`timescale 1ns/10ps
`default_nettype none
`include "lsu_defines.svh"

module lsuDataRam (
  input  logic              clk,
  input  logic              rstN,
  input  lsuPkg::lsuStage1T stage1,
  input  logic              ramWrite,
  input  logic              ramRead,
  input  logic              scFail,
  output lsuPkg::lsuStage2T stage2
);

  localparam int ByteLanes = `LSU_XLEN / 8;

  logic [`LSU_XLEN-1:0] mem [`LSU_MEM_WORDS];
  logic [`LSU_XLEN-1:0] readWord;
  logic                 loadFault;
  logic                 storeFault;

  //////////////////////////////
  // Storage
  //////////////////////////////

  // Byte-enable write, same edge that loads stage two
  always_ff @(posedge clk) begin
    if (ramWrite) begin
      for (int i = 0; i < ByteLanes; i++) begin
        if (stage1.byteEn[i]) begin
          mem[stage1.wordAdr][8*i +: 8] <= stage1.laneData[8*i +: 8];
        end
      end
    end
  end

  // Zero word when no read is enabled
  // so stores, SCs and faults carry no stale data
  assign readWord = ramRead ? mem[stage1.wordAdr] : '0;

  //////////////////////////////
  // Fault split
  //////////////////////////////

  // Loads and LR fault as loads
  assign loadFault = stage1.valid & stage1.misaligned & (stage1.isLoad | stage1.isLr);

  // Stores and SC fault as stores
  assign storeFault = stage1.valid & stage1.misaligned & (stage1.isStore | stage1.isSc);

  //////////////////////////////
  // Stage two register
  //////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      stage2 <= '0;
    end else begin
      stage2.valid <= stage1.valid;
      stage2.funct3 <= stage1.funct3;
      stage2.byteOfs <= stage1.byteOfs;
      stage2.isSc <= stage1.valid & stage1.isSc;
      stage2.scFail <= scFail;
      stage2.loadFault <= loadFault;
      stage2.storeFault <= storeFault;
      // Read word lands together with its op
      stage2.ramWord <= readWord;
    end
  end

  // A write never comes from a misaligned op
  assert property (@(posedge clk) disable iff (!rstN) ramWrite |-> !stage1.misaligned)
    else $error("lsuDataRam: write enabled for a misaligned access");

endmodule

`default_nettype wire

// File: verilog/lsuPkg.sv
// Load/store unit types
`default_nettype none
`include "lsu_defines.svh"

package lsuPkg;

  // Read/write field of a request
  typedef enum logic [1:0] {
    memIdle  = 2'b00,
    memWrite = 2'b01,
    memRead  = 2'b10
  } memRwT;

  // Atomic field, LR rides on a read and SC on a write
  typedef enum logic [1:0] {
    atomicNone = 2'b00,
    atomicSc   = 2'b01,
    atomicLr   = 2'b10
  } atomicT;

  // Request from the core
  typedef struct packed {
    memRwT                memRw;
    atomicT               atomic;
    logic [2:0]           funct3;
    logic [`LSU_XLEN-1:0] adr;
    logic [`LSU_XLEN-1:0] writeData;
  } lsuReqT;

  // Stage one to stage two
  typedef struct packed {
    logic                          valid;
    logic                          isLoad;
    logic                          isStore;
    logic                          isLr;
    logic                          isSc;
    logic                          misaligned;
    logic [2:0]                    funct3;
    logic [1:0]                    byteOfs;
    logic [`LSU_WORD_ADR_BITS-1:0] wordAdr;
    logic [3:0]                    byteEn;
    logic [`LSU_XLEN-1:0]          laneData;
  } lsuStage1T;

  // Stage two to stage three
  typedef struct packed {
    logic                 valid;
    logic [2:0]           funct3;
    logic [1:0]           byteOfs;
    logic                 isSc;
    logic                 scFail;
    logic                 loadFault;
    logic                 storeFault;
    logic [`LSU_XLEN-1:0] ramWord;
  } lsuStage2T;

  // Response to the core
  typedef struct packed {
    logic                 valid;
    logic [`LSU_XLEN-1:0] readData;
    logic                 loadMisalignedFault;
    logic                 storeMisalignedFault;
    logic                 squashSc;
  } lsuRespT;

endpackage

`default_nettype wire

// File: verilog/lsuReservation.sv
// LR/SC reservation
`timescale 1ns/10ps
`default_nettype none
`include "lsu_defines.svh"

module lsuReservation (
  input  logic              clk,
  input  logic              rstN,
  input  lsuPkg::lsuStage1T stage1,
  output logic              ramWrite,
  output logic              ramRead,
  output logic              scFail
);

  logic                          resValid;
  logic [`LSU_WORD_ADR_BITS-1:0] resWordAdr;
  logic                          active;
  logic                          scPass;

  //////////////////////////////
  // Access gating
  //////////////////////////////

  // Live and aligned, a faulted op touches nothing
  assign active = stage1.valid & ~stage1.misaligned;

  // SC needs a live reservation on the same word
  assign scPass = active & stage1.isSc & resValid & (resWordAdr == stage1.wordAdr);

  assign ramWrite = (active & stage1.isStore) | scPass;
  assign ramRead = active & (stage1.isLoad | stage1.isLr);

  // Every SC that does not write reports failure
  assign scFail = stage1.valid & stage1.isSc & ~scPass;

  //////////////////////////////
  // Reservation register
  //////////////////////////////

  // Any SC drops it, pass or fail
  // Plain stores leave it alone
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      resValid <= 1'b0;
    end else if (stage1.valid & stage1.isSc) begin
      resValid <= 1'b0;
    end else if (active & stage1.isLr) begin
      resValid <= 1'b1;
    end
  end

  // Reserved word, only meaningful with resValid
  always_ff @(posedge clk) begin
    if (active & stage1.isLr) begin
      resWordAdr <= stage1.wordAdr;
    end
  end

  // Memory port is either read or written, never both
  assert property (@(posedge clk) disable iff (!rstN) !(ramWrite && ramRead))
    else $error("lsuReservation: ramWrite and ramRead both high");

endmodule

`default_nettype wire

// File: verilog/lsuSubwordRead.sv
// Subword extract and response register
`timescale 1ns/10ps
`default_nettype none
`include "lsu_defines.svh"

module lsuSubwordRead (
  input  logic              clk,
  input  logic              rstN,
  input  lsuPkg::lsuStage2T stage2,
  output lsuPkg::lsuRespT   resp
);

  logic [7:0]           byteSel;
  logic [15:0]          halfSel;
  logic                 signFill;
  logic [`LSU_XLEN-1:0] loadData;
  logic [`LSU_XLEN-1:0] result;

  //////////////////////////////
  // Lane select
  //////////////////////////////
  always_comb begin
    case (stage2.byteOfs)
      2'b00:   byteSel = stage2.ramWord[7:0];
      2'b01:   byteSel = stage2.ramWord[15:8];
      2'b10:   byteSel = stage2.ramWord[23:16];
      default: byteSel = stage2.ramWord[31:24];
    endcase
  end

  // Upper or lower half by offset bit 1
  assign halfSel = stage2.byteOfs[1] ? stage2.ramWord[31:16] : stage2.ramWord[15:0];

  //////////////////////////////
  // Extension
  //////////////////////////////
  // funct3 bit 2 selects unsigned
  always_comb begin
    signFill = 1'b0;
    case (stage2.funct3[1:0])
      2'b00: begin
        signFill = byteSel[7] & ~stage2.funct3[2];
        loadData = {{(`LSU_XLEN-8){signFill}}, byteSel};
      end
      2'b01: begin
        signFill = halfSel[15] & ~stage2.funct3[2];
        loadData = {{(`LSU_XLEN-16){signFill}}, halfSel};
      end
      default: loadData = stage2.ramWord;
    endcase
  end

  // Faults read zero, SC returns its status, stores see a zero word
  always_comb begin
    if (stage2.loadFault | stage2.storeFault) begin
      result = '0;
    end else if (stage2.isSc) begin
      result = {{(`LSU_XLEN-1){1'b0}}, stage2.scFail};
    end else begin
      result = loadData;
    end
  end

  // Response register, valid pulses once per op
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      resp <= '0;
    end else begin
      resp.valid <= stage2.valid;
      resp.readData <= result;
      resp.loadMisalignedFault <= stage2.loadFault;
      resp.storeMisalignedFault <= stage2.storeFault;
      resp.squashSc <= stage2.isSc & stage2.scFail;
    end
  end

  // One op is either a load or a store, never both faults
  assert property (@(posedge clk) disable iff (!rstN)
    !(stage2.loadFault && stage2.storeFault))
    else $error("lsuSubwordRead: load and store fault both set");

endmodule

`default_nettype wire

// File: verilog/lsu_defines.svh
// Load/store unit sizes
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

//////////////////////////////
// Datapath
//////////////////////////////

// Data and address width
`define LSU_XLEN 32

//////////////////////////////
// Local word memory
//////////////////////////////

// Number of words in the local memory
`define LSU_MEM_WORDS 64
// Word index width, log2 of LSU_MEM_WORDS
`define LSU_WORD_ADR_BITS 6

`endif
